// ==== common/rv_mul_defs.svh ====
`ifndef RV_MUL_DEFS_SVH
`define RV_MUL_DEFS_SVH

// Register width of the core
`define RV_XLEN 32

// Half word width used for the 16x16 partial products
`define RV_HALF 16

// One restore step per bit of the dividend
`define DIV_STEPS 32

// Start to done in clock cycles
`define MUL_LATENCY 2
`define DIV_LATENCY 34

`endif

// ==== common/rv_mul_pkg.sv ====
`include "rv_mul_defs.svh"

package rv_mul_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [`RV_HALF-1:0] half_t;
  typedef logic [2*`RV_HALF-1:0] prod_t;

  // funct3 of the M extension, bit 2 set for divides
  typedef logic [2:0] op_t;

  localparam op_t OP_MUL    = 3'b000;
  localparam op_t OP_MULH   = 3'b001;
  localparam op_t OP_MULHSU = 3'b010;
  localparam op_t OP_MULHU  = 3'b011;
  localparam op_t OP_DIV    = 3'b100;
  localparam op_t OP_DIVU   = 3'b101;
  localparam op_t OP_REM    = 3'b110;
  localparam op_t OP_REMU   = 3'b111;

  // Iterative divider states
  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_FIX
  } div_state_t;

endpackage

// ==== mul_ext/mul_ext_div.sv ====
`include "rv_mul_defs.svh"

module mul_ext_div
  import rv_mul_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  start,
  input  op_t   op,
  input  word_t dividend,
  input  word_t divisor,
  output logic  busy,
  output logic  done,
  output word_t result
);

  localparam int CNT_W = $clog2(`DIV_STEPS);

  div_state_t state;
  logic [CNT_W-1:0] count;

  // Quotient register starts out holding the dividend magnitude
  word_t quo;
  word_t rem;
  word_t dvsr;

  // Sign fix-up and result select captured at load
  logic neg_q;
  logic neg_r;
  logic want_rem;

  // Load side decode
  logic  op_signed;
  word_t dividend_abs;
  word_t divisor_abs;

  // One restore step
  logic [`RV_XLEN:0] shifted;
  logic [`RV_XLEN:0] trial;
  logic              fits;

  // Final values
  word_t quo_out;
  word_t rem_out;

  assign op_signed = (op == OP_DIV) || (op == OP_REM);

  assign dividend_abs = (op_signed && dividend[`RV_XLEN-1]) ? -dividend : dividend;
  assign divisor_abs  = (op_signed && divisor[`RV_XLEN-1]) ? -divisor : divisor;

  // Bring in the next dividend bit and try to subtract
  assign shifted = {rem, quo[`RV_XLEN-1]};
  assign trial   = shifted - {1'b0, dvsr};
  assign fits    = shifted >= {1'b0, dvsr};

  // Control FSM
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= DIV_IDLE;
      count <= '0;
    end else begin
      case (state)
        DIV_IDLE: begin
          if (start) begin
            state <= DIV_RUN;
            count <= CNT_W'(`DIV_STEPS - 1);
          end
        end
        DIV_RUN: begin
          if (count == '0) begin
            state <= DIV_FIX;
          end else begin
            count <= count - 1'b1;
          end
        end
        DIV_FIX: begin
          state <= DIV_IDLE;
        end
        default: begin
          state <= DIV_IDLE;
        end
      endcase
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    if (state == DIV_IDLE && start) begin
      quo      <= dividend_abs;
      rem      <= '0;
      dvsr     <= divisor_abs;
      want_rem <= op[1];
      // Zero divisor keeps the all-ones quotient as is
      neg_q    <= op_signed && (dividend[`RV_XLEN-1] ^ divisor[`RV_XLEN-1]) &&
                  (divisor != '0);
      // Remainder takes the sign of the dividend
      neg_r    <= op_signed && dividend[`RV_XLEN-1];
    end else if (state == DIV_RUN) begin
      if (fits) begin
        rem <= trial[`RV_XLEN-1:0];
      end else begin
        rem <= shifted[`RV_XLEN-1:0];
      end
      quo <= {quo[`RV_XLEN-2:0], fits};
    end
  end

  // With a zero divisor every step fits, so the quotient ends all ones
  // and the remainder ends as the dividend magnitude
  // Overflow gives quotient 0x80000000 with both signs set, left as is
  assign quo_out = neg_q ? -quo : quo;
  assign rem_out = neg_r ? -rem : rem;

  assign result = want_rem ? rem_out : quo_out;

  // Done is the single FIX cycle
  assign done = (state == DIV_FIX);
  assign busy = (state != DIV_IDLE);

endmodule

// ==== mul_ext/mul_ext_ex.sv ====
`include "rv_mul_defs.svh"

module mul_ext_ex
  import rv_mul_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  start,
  input  op_t   op,
  input  word_t rs1_data,
  input  word_t rs2_data,
  output prod_t mul_ll,
  output prod_t mul_lh,
  output prod_t mul_hl,
  output prod_t mul_hh,
  output word_t rs1_q,
  output word_t rs2_q,
  output op_t   op_q,
  output logic  mul_valid,
  output logic  busy,
  output logic  div_done,
  output word_t div_result
);

  // Request qualification
  logic accept;
  logic mul_start;
  logic div_start;

  // Operand halves
  half_t a_lo;
  half_t a_hi;
  half_t b_lo;
  half_t b_hi;

  // Only the divider can hold the unit busy
  assign accept    = start && !busy;
  assign mul_start = accept && !op[2];
  assign div_start = accept && op[2];

  assign a_lo = rs1_data[`RV_HALF-1:0];
  assign a_hi = rs1_data[`RV_XLEN-1:`RV_HALF];
  assign b_lo = rs2_data[`RV_HALF-1:0];
  assign b_hi = rs2_data[`RV_XLEN-1:`RV_HALF];

  // Multiply strobe toward MEM, one cycle after capture
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mul_valid <= 1'b0;
    end else begin
      mul_valid <= mul_start;
    end
  end

  // Captured request payload
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q <= op;
    end
    if (mul_start) begin
      // Unsigned 16x16 products, signs are fixed up in MEM
      mul_ll <= prod_t'(a_lo) * prod_t'(b_lo);
      mul_lh <= prod_t'(a_lo) * prod_t'(b_hi);
      mul_hl <= prod_t'(a_hi) * prod_t'(b_lo);
      mul_hh <= prod_t'(a_hi) * prod_t'(b_hi);
      // Operands kept for the MULH sign correction
      rs1_q  <= rs1_data;
      rs2_q  <= rs2_data;
    end
  end

  // Iterative divider for DIV, DIVU, REM and REMU
  mul_ext_div div0 (
    .clk      (clk),
    .arst_n   (arst_n),
    .start    (div_start),
    .op       (op),
    .dividend (rs1_data),
    .divisor  (rs2_data),
    .busy     (busy),
    .done     (div_done),
    .result   (div_result)
  );

endmodule

// ==== mul_ext/mul_ext_mem.sv ====
`include "rv_mul_defs.svh"

module mul_ext_mem
  import rv_mul_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  mul_valid,
  input  logic  div_done,
  input  prod_t mul_ll,
  input  prod_t mul_lh,
  input  prod_t mul_hl,
  input  prod_t mul_hh,
  input  word_t div_result,
  input  word_t rs1_data,
  input  word_t rs2_data,
  input  op_t   op,
  output logic  done,
  output word_t result
);

  // Cross products summed with their carry
  logic [`RV_XLEN:0]     mid_sum;
  logic [2*`RV_XLEN-1:0] product;

  // Sign correction
  logic  rs1_signed;
  logic  rs2_signed;
  word_t corr_a;
  word_t corr_b;
  word_t upper;

  word_t mul_result;
  word_t next_result;

  assign mid_sum = {1'b0, mul_lh} + {1'b0, mul_hl};

  // Middle sum lands at bit 16 of the full product
  assign product = {
    ({mul_hh, mul_ll[`RV_XLEN-1:`RV_HALF]} + {{(`RV_HALF-1){1'b0}}, mid_sum}),
    mul_ll[`RV_HALF-1:0]
  };

  assign rs1_signed = (op == OP_MULH) || (op == OP_MULHSU);
  assign rs2_signed = (op == OP_MULH);

  // A negative signed operand counts as value minus 2^32,
  // so the other operand comes off the upper word
  assign corr_a = (rs1_signed && rs1_data[`RV_XLEN-1]) ? rs2_data : '0;
  assign corr_b = (rs2_signed && rs2_data[`RV_XLEN-1]) ? rs1_data : '0;

  assign upper = product[2*`RV_XLEN-1:`RV_XLEN] - corr_a - corr_b;

  // MUL takes the low word, MULH, MULHSU and MULHU the corrected high word
  assign mul_result = (op == OP_MUL) ? product[`RV_XLEN-1:0] : upper;

  assign next_result = op[2] ? div_result : mul_result;

  // One-cycle done strobe
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done <= 1'b0;
    end else begin
      done <= mul_valid || div_done;
    end
  end

  // Result only updates on a completing operation
  always_ff @(posedge clk) begin
    if (mul_valid || div_done) begin
      result <= next_result;
    end
  end

endmodule

// ==== rv_mul.f ====
+incdir+common
common/rv_mul_pkg.sv
mul_ext/mul_ext_div.sv
mul_ext/mul_ext_ex.sv
mul_ext/mul_ext_mem.sv
src/mul_ext_top.sv
testbench/mul_ext_checker.sv
testbench/mul_ext_tb.sv

// ==== src/mul_ext_top.sv ====
module mul_ext_top
  import rv_mul_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  start,
  input  op_t   op,
  input  word_t rs1_data,
  input  word_t rs2_data,
  output logic  busy,
  output logic  done,
  output word_t result
);

  // EX to MEM pipeline signals
  prod_t mul_ll;
  prod_t mul_lh;
  prod_t mul_hl;
  prod_t mul_hh;
  word_t rs1_q;
  word_t rs2_q;
  op_t   op_q;
  logic  mul_valid;
  logic  div_done;
  word_t div_result;

  mul_ext_ex ex0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .start      (start),
    .op         (op),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .mul_ll     (mul_ll),
    .mul_lh     (mul_lh),
    .mul_hl     (mul_hl),
    .mul_hh     (mul_hh),
    .rs1_q      (rs1_q),
    .rs2_q      (rs2_q),
    .op_q       (op_q),
    .mul_valid  (mul_valid),
    .busy       (busy),
    .div_done   (div_done),
    .div_result (div_result)
  );

  // MEM sees the captured operands and op
  mul_ext_mem mem0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .mul_valid  (mul_valid),
    .div_done   (div_done),
    .mul_ll     (mul_ll),
    .mul_lh     (mul_lh),
    .mul_hl     (mul_hl),
    .mul_hh     (mul_hh),
    .div_result (div_result),
    .rs1_data   (rs1_q),
    .rs2_data   (rs2_q),
    .op         (op_q),
    .done       (done),
    .result     (result)
  );

endmodule

// ==== testbench/mul_ext_checker.sv ====
`include "rv_mul_defs.svh"

module mul_ext_checker
  import rv_mul_pkg::*;
(
  input logic clk,
  input logic arst_n,
  input logic start,
  input op_t  op,
  input logic busy,
  input logic done
);

  // Number of failed assertions so far
  int unsigned fail_count = 0;

  logic mul_accept;
  logic div_accept;

  // Same acceptance rule as the EX stage
  assign mul_accept = start && !busy && !op[2];
  assign div_accept = start && !busy && op[2];

  // Done never repeats, except for multiplies started on consecutive cycles
  done_single: assert property (@(posedge clk) disable iff (!arst_n)
    done |=> !done || $past(mul_accept, `MUL_LATENCY))
    else begin
      $error("done high on two consecutive cycles");
      fail_count++;
    end

  // Fixed multiply latency
  mul_timing: assert property (@(posedge clk) disable iff (!arst_n)
    mul_accept |-> ##`MUL_LATENCY done)
    else begin
      $error("multiply done not at MUL_LATENCY");
      fail_count++;
    end

  // Busy covers the whole divide, done one cycle after busy drops
  div_timing: assert property (@(posedge clk) disable iff (!arst_n)
    div_accept |=> busy [*(`DIV_LATENCY-1)] ##1 done)
    else begin
      $error("divide busy or done timing wrong");
      fail_count++;
    end

endmodule

bind mul_ext_top mul_ext_checker checker0 (
  .clk    (clk),
  .arst_n (arst_n),
  .start  (start),
  .op     (op),
  .busy   (busy),
  .done   (done)
);

// ==== testbench/mul_ext_tb.sv ====
`include "rv_mul_defs.svh"

module mul_ext_tb
  import rv_mul_pkg::*;
();

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 4;
  localparam int N_DIRECTED   = 24;
  localparam int N_RANDOM     = 16;
  localparam int N_ROWS       = N_DIRECTED + N_RANDOM;
  // Busy and back-to-back sequences count as rows
  localparam int N_EXTRA      = 4;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + (N_ROWS + N_EXTRA) * (`DIV_LATENCY + 4);

  logic  clk;
  logic  arst_n;
  logic  start;
  op_t   op;
  word_t rs1_data;
  word_t rs2_data;
  logic  busy;
  logic  done;
  word_t result;

  // Stimulus table with the directed rows first
  op_t   tab_op  [N_ROWS];
  word_t tab_rs1 [N_ROWS];
  word_t tab_rs2 [N_ROWS];
  word_t tab_exp [N_ROWS];

  logic [15:0] lfsr;
  int          done_count;

  mul_ext_top dut0 (
    .clk      (clk),
    .arst_n   (arst_n),
    .start    (start),
    .op       (op),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .busy     (busy),
    .done     (done),
    .result   (result)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  // Galois form of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end else begin
      return s >> 1;
    end
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output word_t val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[`RV_XLEN-2:0], lfsr[0]};
    end
  endtask

  // Reference in 64-bit arithmetic on sign and zero extended operands
  function automatic word_t ref_model(input op_t f, input word_t a, input word_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] za;
    logic signed [63:0] zb;
    logic signed [63:0] r;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    za = {32'd0, a};
    zb = {32'd0, b};
    // Overflow quotient 2^31 truncates to the most negative value
    case (f)
      OP_MUL:    r = za * zb;
      OP_MULH:   r = (sa * sb) >>> 32;
      OP_MULHSU: r = (sa * zb) >>> 32;
      OP_MULHU:  r = (za * zb) >>> 32;
      // Divide by zero gives all ones and the remainder keeps the dividend
      OP_DIV:    r = (b == '0) ? -64'sd1 : sa / sb;
      OP_DIVU:   r = (b == '0) ? -64'sd1 : za / zb;
      OP_REM:    r = (b == '0) ? sa : sa % sb;
      default:   r = (b == '0) ? za : za % zb;
    endcase
    return r[31:0];
  endfunction

  task automatic set_row(input int i, input op_t f, input word_t a, input word_t b,
                         input word_t e);
    tab_op[i]  = f;
    tab_rs1[i] = a;
    tab_rs2[i] = b;
    tab_exp[i] = e;
  endtask

  task automatic check_value(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s returned %h, expected %h", $time, what, got, exp);
      $display("tests failed");
      $fatal(1, "Value mismatch");
    end
  endtask

  // Called on a falling edge and holds start for one cycle
  task automatic issue(input op_t f, input word_t a, input word_t b);
    start    = 1'b1;
    op       = f;
    rs1_data = a;
    rs2_data = b;
    @(negedge clk);
    start    = 1'b0;
  endtask

  // Samples done on falling edges where done and result have settled
  task automatic wait_done();
    while (!done) begin
      @(negedge clk);
    end
  endtask

  initial begin
    int    i;
    word_t f;
    word_t a;
    word_t b;
    clk      = 1'b0;
    arst_n   = 1'b0;
    start    = 1'b0;
    op       = OP_MUL;
    rs1_data = '0;
    rs2_data = '0;
    lfsr     = 16'd24396;

    // Low word of the product whatever the signs
    set_row(0, OP_MUL, 32'h00000003, 32'h00000005, 32'h0000000F);
    set_row(1, OP_MUL, 32'hFFFFFFFE, 32'h00000003, 32'hFFFFFFFA);
    set_row(2, OP_MUL, 32'h00010000, 32'h00010000, 32'h00000000);
    set_row(3, OP_MUL, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'h00000001);
    // High word for signed by signed
    set_row(4, OP_MULH, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'h00000000);
    set_row(5, OP_MULH, 32'h80000000, 32'h80000000, 32'h40000000);
    set_row(6, OP_MULH, 32'hFFFFFFFE, 32'h00000003, 32'hFFFFFFFF);
    set_row(7, OP_MULH, 32'h7FFFFFFF, 32'h7FFFFFFF, 32'h3FFFFFFF);
    // Signed by unsigned and then unsigned by unsigned
    set_row(8, OP_MULHSU, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'hFFFFFFFF);
    set_row(9, OP_MULHSU, 32'h00000002, 32'h80000000, 32'h00000001);
    set_row(10, OP_MULHU, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'hFFFFFFFE);
    set_row(11, OP_MULHU, 32'h80000000, 32'h00000002, 32'h00000001);
    // Truncating quotient and a remainder that follows the dividend
    set_row(12, OP_DIV, 32'h00000014, 32'h00000003, 32'h00000006);
    set_row(13, OP_DIV, 32'hFFFFFFEC, 32'h00000003, 32'hFFFFFFFA);
    set_row(14, OP_DIVU, 32'hFFFFFFFE, 32'h00000002, 32'h7FFFFFFF);
    set_row(15, OP_REM, 32'hFFFFFFEC, 32'h00000003, 32'hFFFFFFFE);
    set_row(16, OP_REM, 32'h00000014, 32'hFFFFFFFD, 32'h00000002);
    set_row(17, OP_REMU, 32'hFFFFFFFF, 32'h0000000A, 32'h00000005);
    // Zero divisor and signed overflow
    set_row(18, OP_DIV, 32'h00000007, 32'h00000000, 32'hFFFFFFFF);
    set_row(19, OP_REM, 32'hFFFFFFFB, 32'h00000000, 32'hFFFFFFFB);
    set_row(20, OP_DIV, 32'h80000000, 32'hFFFFFFFF, 32'h80000000);
    set_row(21, OP_REM, 32'h80000000, 32'hFFFFFFFF, 32'h00000000);
    set_row(22, OP_DIVU, 32'h80000001, 32'h00000000, 32'hFFFFFFFF);
    set_row(23, OP_REMU, 32'h80000001, 32'h00000000, 32'h80000001);
    for (i = N_DIRECTED; i < N_ROWS; i++) begin
      take_bits(3, f);
      take_bits(`RV_XLEN, a);
      take_bits(`RV_XLEN, b);
      set_row(i, op_t'(f[2:0]), a, b, ref_model(op_t'(f[2:0]), a, b));
    end

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    for (i = 0; i < N_ROWS; i++) begin
      issue(tab_op[i], tab_rs1[i], tab_rs2[i]);
      wait_done();
      check_value($sformatf("row %0d op %0d", i, tab_op[i]), result, tab_exp[i]);
    end

    // Multiply requests while the divider runs must be dropped
    issue(OP_DIVU, 32'd100, 32'd7);
    start    = 1'b1;
    op       = OP_MUL;
    rs1_data = 32'd3;
    rs2_data = 32'd5;
    repeat (3) @(negedge clk);
    start      = 1'b0;
    done_count = 0;
    repeat (`DIV_LATENCY + 4) begin
      if (done) begin
        done_count++;
        check_value("DIVU under busy", result, 32'd14);
      end
      @(negedge clk);
    end
    check_value("done pulses under busy", done_count, 1);

    // Two multiplies in flight at once
    start    = 1'b1;
    op       = OP_MULHU;
    rs1_data = 32'hFFFFFFFF;
    rs2_data = 32'hFFFFFFFF;
    @(negedge clk);
    op       = OP_MUL;
    rs1_data = 32'd1234;
    rs2_data = 32'd5678;
    @(negedge clk);
    start = 1'b0;
    wait_done();
    check_value("first back-to-back MULHU", result, 32'hFFFFFFFE);
    @(negedge clk);
    check_value("second back-to-back done", done, 1);
    check_value("second back-to-back MUL", result, 32'd7006652);

    @(negedge clk);
    $display("all tests passed");
    $finish;
  end

  // Stops the run as soon as a checker assertion fails
  initial begin
    wait (dut0.checker0.fail_count != 0);
    $display("Checker assertion failed at %0t, done or busy timing is wrong", $time);
    $display("tests failed");
    $fatal(1, "Assertion failure");
  end

  // Ends a run in which done never shows up
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, done never arrived", WATCHDOG_CYCLES);
    $display("tests failed");
    $fatal(1, "Timeout");
  end

endmodule
